//--- hdl/obj_pkg.sv
// object layer package: sizes, widths and object table field positions

package obj_pkg;

    // object table
    localparam int obj_num  = 16;
    localparam int obj_aw   = 4;
    localparam int entry_w  = 32;

    // sprite geometry
    localparam int obj_size = 16;
    localparam int pos_w    = 8;   // x, y and line numbers
    localparam int row_w    = 4;   // row inside one sprite
    localparam int h_offset = 6;

    // graphics ROM, word address is {code, row, half}
    localparam int code_w   = 9;
    localparam int rom_aw   = 14;
    localparam int rom_dw   = 32;

    // colour path
    localparam int pxl_w    = 4;
    localparam int pal_aw   = 8;   // {palette number, pixel}
    localparam int buf_aw   = 8;

    // object table word layout, top bit down
    localparam int vflip_bit = 31;
    localparam int hflip_bit = 30;
    localparam int pal_lsb   = 26;
    localparam int code_lsb  = 17;
    // bit 16 is spare
    localparam int x_lsb     = 8;
    localparam int y_lsb     = 0;

endpackage

//--- hdl/obj_scan.sv
// object scanner: holds the sprite table and hands each hit on the next line to the drawer
`timescale 1ns/1ns

module obj_scan (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hinit,
    input  logic [obj_pkg::pos_w-1:0]     vrender,
    input  logic                          tbl_we,
    input  logic [obj_pkg::obj_aw-1:0]    tbl_addr,
    input  logic [obj_pkg::entry_w-1:0]   tbl_din,
    input  logic                          busy,
    output logic                          draw,
    output logic [obj_pkg::pos_w-1:0]     xpos,
    output logic [obj_pkg::row_w-1:0]     ysub,
    output logic [obj_pkg::pxl_w-1:0]     pal,
    output logic                          hflip,
    output logic                          vflip,
    output logic [obj_pkg::code_w-1:0]    code
);
    import obj_pkg::*;

    logic [entry_w-1:0] tbl [obj_num];
    logic [obj_aw-1:0]  idx;
    logic               active;    // still walking the table this line
    logic [entry_w-1:0] entry;
    logic [pos_w-1:0]   dy;
    logic               hit;
    logic               test;

    assign entry = tbl[idx];
    assign dy    = vrender - entry[y_lsb +: pos_w];  // wraps mod 256
    assign hit   = dy < pos_w'(obj_size);
    // one entry per clock, but only while no object is pending or drawing
    assign test  = active && !draw && !busy;

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_din;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            idx    <= '0;
            draw   <= 1'b0;
        end else if (hinit) begin
            active <= 1'b1;  // new line, start over at entry 0
            idx    <= '0;
            draw   <= 1'b0;
        end else begin
            if (draw && busy) begin
                draw <= 1'b0;  // drawer took it
            end
            if (test) begin
                if (hit) begin
                    draw <= 1'b1;
                end
                idx <= idx + 1'b1;
                if (idx == obj_aw'(obj_num - 1)) begin
                    active <= 1'b0;  // last entry tested
                end
            end
        end
    end

    // fields held steady until the next hit
    always_ff @(posedge clk) begin
        if (test && hit) begin
            xpos  <= entry[x_lsb +: pos_w];
            ysub  <= dy[row_w-1:0];
            pal   <= entry[pal_lsb +: pxl_w];
            code  <= entry[code_lsb +: code_w];
            hflip <= entry[hflip_bit];
            vflip <= entry[vflip_bit];
        end
    end

endmodule

//--- hdl/obj_draw.sv
// object drawer: fetches two ROM words per sprite row and shifts pixels into the line buffer
`timescale 1ns/1ns

module obj_draw (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          draw,
    input  logic [obj_pkg::pos_w-1:0]     xpos,
    input  logic [obj_pkg::row_w-1:0]     ysub,
    input  logic [obj_pkg::pxl_w-1:0]     pal,
    input  logic                          hflip,
    input  logic                          vflip,
    input  logic [obj_pkg::code_w-1:0]    code,
    input  logic [obj_pkg::rom_dw-1:0]    rom_data,
    input  logic                          rom_ok,
    output logic                          busy,
    output logic                          rom_cs,
    output logic [obj_pkg::rom_aw-1:0]    rom_addr,
    output logic [obj_pkg::pal_aw-1:0]    pal_addr,
    output logic                          buf_we,
    output logic [obj_pkg::buf_aw-1:0]    buf_addr
);
    import obj_pkg::*;

    logic [rom_dw-1:0] pxl_data;   // packed nibbles, lowest goes out first
    logic [2:0]        cnt;
    logic              hflip_r;
    logic [pxl_w-1:0]  pal_r;
    logic              accept;
    logic              fetched;

    assign accept   = draw && !busy;
    assign fetched  = rom_cs && rom_ok;
    assign pal_addr = {pal_r, pxl_data[pxl_w-1:0]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            buf_we   <= 1'b0;
            cnt      <= '0;
        end else begin
            if (accept) begin
                busy     <= 1'b1;
                rom_cs   <= 1'b1;
                rom_addr <= {code, ysub ^ {row_w{vflip}}, 1'b0};  // half 0 first
            end else if (rom_cs) begin
                if (rom_ok) begin
                    rom_cs <= 1'b0;
                    buf_we <= 1'b1;  // eight writes follow
                    cnt    <= 3'd7;
                end
            end else if (buf_we) begin
                cnt <= cnt - 3'd1;
                if (cnt == 3'd0) begin
                    buf_we <= 1'b0;
                    if (rom_addr[0]) begin
                        busy <= 1'b0;  // both halves done
                    end else begin
                        rom_addr[0] <= 1'b1;
                        rom_cs      <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hflip_r  <= hflip;
            pal_r    <= pal;
            // mirrored sprites start at the right edge and walk left
            buf_addr <= xpos + buf_aw'(h_offset)
                      + (hflip ? buf_aw'(obj_size - 1) : buf_aw'(0));
        end
        if (fetched) begin
            pxl_data <= rom_data;
        end else if (buf_we) begin
            pxl_data <= pxl_data >> pxl_w;
            buf_addr <= hflip_r ? buf_addr - 1'b1 : buf_addr + 1'b1;
        end
    end

endmodule

//--- hdl/obj_palette.sv
// sprite palette PROM, 256 by 4, written from the CPU port and read combinationally
`timescale 1ns/1ns

module obj_palette (
    input  logic                          clk,
    input  logic                          prog_en,
    input  logic [obj_pkg::pal_aw-1:0]    prog_addr,
    input  logic [obj_pkg::pxl_w-1:0]     prog_data,
    input  logic [obj_pkg::pal_aw-1:0]    rd_addr,
    output logic [obj_pkg::pxl_w-1:0]     rd_data
);
    import obj_pkg::*;

    logic [pxl_w-1:0] mem [2**pal_aw];

    // all colours transparent until programmed
    initial begin
        for (int i = 0; i < 2**pal_aw; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign rd_data = mem[rd_addr];  // lines up with the drawer's write

endmodule

//--- hdl/obj_linebuf.sv
// double line buffer: one bank is drawn while the other is shown and erased
`timescale 1ns/1ns

module obj_linebuf (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hinit,
    input  logic                          we,
    input  logic [obj_pkg::buf_aw-1:0]    wr_addr,
    input  logic [obj_pkg::pxl_w-1:0]     wr_data,
    input  logic                          rd,
    input  logic [obj_pkg::buf_aw-1:0]    rd_addr,
    output logic [obj_pkg::pxl_w-1:0]     rd_data
);
    import obj_pkg::*;

    logic [pxl_w-1:0]  mem [2 * 2**buf_aw];  // bank select is the top address bit
    logic              bank;                 // bank being drawn
    logic [buf_aw:0]   wr_full;
    logic [buf_aw:0]   rd_full;
    logic              opaque;

    assign wr_full = {bank, wr_addr};
    assign rd_full = {~bank, rd_addr};
    assign opaque  = wr_data != '0;

    initial begin
        for (int i = 0; i < 2 * 2**buf_aw; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank    <= 1'b0;
            rd_data <= '0;
        end else begin
            if (hinit) begin
                bank <= ~bank;  // last line's drawing goes on screen
            end
            if (rd) begin
                rd_data <= mem[rd_full];
            end
        end
    end

    // banks never overlap, so draw and erase can share the cycle
    always_ff @(posedge clk) begin
        if (we && opaque) begin
            mem[wr_full] <= wr_data;
        end
        if (rd) begin
            mem[rd_full] <= '0;  // erase behind the beam
        end
    end

endmodule

//--- hdl/obj_video.sv
// object layer top: scanner, drawer, palette and line buffer
`timescale 1ns/1ns

module obj_video (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hinit,
    input  logic [obj_pkg::pos_w-1:0]     vrender,
    input  logic [8:0]                    hdump,
    input  logic                          lhbl,
    input  logic                          pxl_cen,
    input  logic                          tbl_we,
    input  logic [obj_pkg::obj_aw-1:0]    tbl_addr,
    input  logic [obj_pkg::entry_w-1:0]   tbl_din,
    input  logic                          prog_en,
    input  logic [obj_pkg::pal_aw-1:0]    prog_addr,
    input  logic [obj_pkg::pxl_w-1:0]     prog_data,
    output logic                          rom_cs,
    output logic [obj_pkg::rom_aw-1:0]    rom_addr,
    input  logic [obj_pkg::rom_dw-1:0]    rom_data,
    input  logic                          rom_ok,
    output logic [obj_pkg::pxl_w-1:0]     pxl
);
    import obj_pkg::*;

    logic              draw;
    logic              busy;
    logic [pos_w-1:0]  xpos;
    logic [row_w-1:0]  ysub;
    logic [pxl_w-1:0]  pal;
    logic              hflip;
    logic              vflip;
    logic [code_w-1:0] code;
    logic [pal_aw-1:0] pal_addr;
    logic [pxl_w-1:0]  colour;
    logic              buf_we;
    logic [buf_aw-1:0] buf_addr;

    obj_scan u_scan (
        .clk, .rst, .hinit, .vrender, .tbl_we, .tbl_addr, .tbl_din, .busy,
        .draw, .xpos, .ysub, .pal, .hflip, .vflip, .code
    );

    obj_draw u_draw (
        .clk, .rst, .draw, .xpos, .ysub, .pal, .hflip, .vflip, .code,
        .rom_data, .rom_ok, .busy, .rom_cs, .rom_addr, .pal_addr, .buf_we, .buf_addr
    );

    obj_palette u_palette (
        .clk, .prog_en, .prog_addr, .prog_data,
        .rd_addr (pal_addr),
        .rd_data (colour)
    );

    obj_linebuf u_linebuf (
        .clk, .rst, .hinit,
        .we      (buf_we),
        .wr_addr (buf_addr),
        .wr_data (colour),
        .rd      (pxl_cen && lhbl),  // scan-out only in active video
        .rd_addr (hdump[buf_aw-1:0]),
        .rd_data (pxl)
    );

endmodule

//--- verif/obj_video_sva.sv
// bound checks on the drawer's ROM handshake, reset state and buffer writes
`timescale 1ns/1ns

module obj_video_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        busy,
    input logic                        rom_cs,
    input logic                        rom_ok,
    input logic [obj_pkg::rom_aw-1:0]  rom_addr,
    input logic                        buf_we
);

    // request held until the ROM answers
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom_cs or rom_addr changed before rom_ok");

    a_reset_idle: assert property (@(posedge clk) rst |=> !busy && !rom_cs && !buf_we)
        else $error("drawer not idle after reset");

    a_we_busy: assert property (@(posedge clk) disable iff (rst) buf_we |-> busy)
        else $error("buf_we high while busy is low");

endmodule

bind obj_draw obj_video_sva u_sva (
    .clk, .rst, .busy, .rom_cs, .rom_ok, .rom_addr, .buf_we
);

//--- verif/obj_video_tb.sv
// testbench for the object layer with line timing, ROM model, reference line model and pixel checks
`timescale 1ns/1ns

module obj_video_tb;

    localparam int line_len = 640;
    localparam int n_lines  = 35;                          // five tests of 3 lines, 20 random
    localparam int limit    = n_lines * line_len + 2000;

    logic        clk = 1'b0;
    logic        rst, hinit, lhbl, pxl_cen, tbl_we, prog_en, rom_cs;
    logic [7:0]  vrender, prog_addr;
    logic [8:0]  hdump;
    logic [3:0]  tbl_addr, prog_data, pxl;
    logic [31:0] tbl_din;
    logic [13:0] rom_addr;
    logic [31:0] rom_data  = '0;
    logic        rom_ok    = 1'b0;
    logic        rom_wait  = 1'b0;
    logic [1:0]  rom_delay = '0;

    logic [31:0] rom [16384];
    logic [31:0] tbl_m [16];
    logic [3:0]  pal_m [256];
    logic [3:0]  shown [256];      // expected pxl on the current line
    logic [3:0]  drawing [256];    // what the DUT draws during the current line
    logic [11:0] pal_q [$];        // {address, colour} waiting for the write window
    logic [31:0] stim_st = 32'heb3aeed2;
    logic [31:0] lat_st  = 32'heb3aeed2;
    logic [7:0]  vline   = 8'd236; // near the bottom so the random lines wrap
    int          cycles = 0, err_cnt = 0, test_cnt = 0, fail_cnt = 0, mark = 0, i, n;

    obj_video u_obj_video (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] rand_bits(input int cnt);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < cnt; k++) begin
            v       = {v[30:0], stim_st[31]};
            stim_st = lfsr_step(stim_st);
        end
        return v;
    endfunction

    // entry that hits the next drawn line at row ysub
    function automatic logic [31:0] make_entry(input logic vf, input logic hf,
            input logic [3:0] pl, input logic [8:0] cd, input logic [7:0] x,
            input logic [7:0] ysub);
        return {vf, hf, pl, cd, 1'b0, x, vline - ysub};
    endfunction

    task automatic clear_table();
        for (int k = 0; k < 16; k++) begin
            tbl_m[k] = {24'h0, vline + 8'd100};  // far from any line drawn soon
        end
    endtask

    task automatic set_pal(input logic [7:0] a, input logic [3:0] d);
        pal_m[a] = d;
        pal_q.push_back({a, d});
    endtask

    // replays the table in order onto the line drawn with vrender v
    task automatic model_line(input logic [7:0] v);
        logic [31:0] e, word;
        logic [7:0]  dy, pos;
        logic [3:0]  row, nib, col;
        int          p, k;
        for (p = 0; p < 256; p++) begin
            drawing[p] = '0;
        end
        for (k = 0; k < 16; k++) begin
            e  = tbl_m[k];
            dy = v - e[7:0];
            if (dy < 8'd16) begin
                row = dy[3:0] ^ {4{e[31]}};
                for (p = 0; p < 16; p++) begin
                    word = rom[{e[25:17], row, p[3]}];
                    nib  = word[4 * (p % 8) +: 4];
                    col  = pal_m[{e[29:26], nib}];
                    pos  = e[15:8] + 8'd6 + (e[30] ? 8'(15 - p) : 8'(p));
                    if (col != 4'd0) begin
                        drawing[pos] = col;
                    end
                end
            end
        end
    endtask

    task automatic run_line();
        int h;
        for (h = 0; h < line_len; h++) begin
            @(posedge clk);
            #1;
            if (h >= 1 && h <= 256) begin
                assert (pxl === shown[h - 1]) else begin
                    $display("mismatch pxl at hdump %0d: got %h, expected %h",
                             h - 1, pxl, shown[h - 1]);
                    err_cnt++;
                end
            end
            hdump    = 9'(h);
            lhbl     = h < 256;
            hinit    = h == line_len - 1;
            tbl_we   = h >= 560 && h < 576;  // scanner and drawer idle by now
            tbl_addr = 4'(h - 560);
            tbl_din  = tbl_m[4'(h - 560)];
            prog_en  = h >= 580 && pal_q.size() > 0;
            if (prog_en) begin
                {prog_addr, prog_data} = pal_q.pop_front();
            end
            if (hinit) begin
                vrender = vline;
            end
        end
        for (h = 0; h < 256; h++) begin
            shown[h] = drawing[h];
        end
        model_line(vline);
        vline++;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == mark) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAIL with %0d mismatches", test_cnt, name, err_cnt - mark);
        end
        mark = err_cnt;
    endtask

    // graphics ROM, answers after 0 to 3 extra cycles
    always @(posedge clk) begin
        #1;
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (!rom_wait) begin
                rom_delay = lat_st[1:0];
                lat_st    = lfsr_step(lfsr_step(lat_st));
                rom_wait  = 1'b1;
            end
            if (rom_delay == 2'd0) begin
                rom_ok   = 1'b1;
                rom_data = rom[rom_addr];
                rom_wait = 1'b0;
            end else begin
                rom_delay = rom_delay - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout, the run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        hinit     = 1'b0;
        lhbl      = 1'b0;
        pxl_cen   = 1'b1;
        hdump     = '0;
        vrender   = '0;
        tbl_we    = 1'b0;
        tbl_addr  = '0;
        tbl_din   = '0;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        for (n = 0; n < 16384; n++) begin
            rom[n] = rand_bits(32);
        end
        for (n = 0; n < 256; n++) begin
            shown[n]   = '0;
            drawing[n] = '0;
            set_pal(8'(n), 4'(rand_bits(4)));
        end
        clear_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (pal_q.size() > 0) begin
            @(posedge clk);
            #1;
            {prog_addr, prog_data} = pal_q.pop_front();
            prog_en = 1'b1;
        end

        for (i = 0; i < 16; i++) begin
            set_pal({4'd5, 4'(i)}, 4'(i));
        end
        tbl_m[0] = make_entry(1'b0, 1'b0, 4'd5, 9'h0a3, 8'd50, 8'd3);
        repeat (3) run_line();
        end_test("single object");

        // one code three ways so the mirror images can be compared
        clear_table();
        tbl_m[2] = make_entry(1'b0, 1'b1, 4'd5, 9'h111, 8'd30, 8'd5);
        tbl_m[5] = make_entry(1'b1, 1'b0, 4'd5, 9'h111, 8'd90, 8'd5);
        tbl_m[9] = make_entry(1'b1, 1'b1, 4'd5, 9'h111, 8'd150, 8'd5);
        repeat (3) run_line();
        end_test("hflip and vflip");

        clear_table();
        for (i = 0; i < 16; i++) begin
            set_pal({4'd9, 4'(i)}, i < 4 ? 4'd0 : 4'(i));  // low nibbles see through
        end
        tbl_m[1] = make_entry(1'b0, 1'b0, 4'd5, 9'h040, 8'd60, 8'd7);
        tbl_m[3] = make_entry(1'b0, 1'b0, 4'd9, 9'h1c5, 8'd66, 8'd7);
        repeat (3) run_line();
        end_test("overlap priority");

        for (i = 1; i < 16; i++) begin
            set_pal({4'd5, 4'(i)}, 4'(16 - i));
        end
        repeat (3) run_line();
        end_test("palette reprogram");

        for (i = 0; i < 20; i++) begin
            for (n = 0; n < 16; n++) begin
                tbl_m[n] = make_entry(rand_bits(1) != 0, rand_bits(1) != 0,
                                      4'(rand_bits(4)), 9'(rand_bits(9)),
                                      8'(rand_bits(8)), 8'(rand_bits(5)));
            end
            run_line();
        end
        end_test("random tables");

        clear_table();
        repeat (3) run_line();
        end_test("empty line after objects");

        $display("%0d tests, %0d failed, %0d mismatches", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- obj_video.f
hdl/obj_pkg.sv
hdl/obj_scan.sv
hdl/obj_draw.sv
hdl/obj_palette.sv
hdl/obj_linebuf.sv
hdl/obj_video.sv
verif/obj_video_sva.sv
verif/obj_video_tb.sv

//--- run.sh
#!/bin/sh
# build the object layer testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -f obj_video.f --top-module obj_video_tb \
    -o sim_obj_video || exit 1
./obj_dir/sim_obj_video > sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
